// File: hdl/alu_unit.sv
`timescale 1ns/1ps

module alu_unit import ooo_pkg::*; #(
  parameter int TAG_W  = 6,
  parameter int DATA_W = 32
) (
  input  logic   clk,
  input  logic   rst_n,
  input  logic   go,
  input  issue_t issue,
  input  logic   result_ready,
  output logic   can_accept,
  output logic   res_valid,
  output cdb_t   res,
  output cdb_t   cdb
);

  logic              full_q;
  logic [TAG_W-1:0]  tag_q;
  logic [DATA_W-1:0] value_q;
  logic [DATA_W-1:0] a;
  logic [DATA_W-1:0] b;
  logic [DATA_W-1:0] alu_out;

  assign a = issue.v1;
  assign b = issue.v2;

  always_comb begin
    case (issue.uop.op)
      op_add:  alu_out = a + b;
      op_sub:  alu_out = a - b;
      op_and:  alu_out = a & b;
      op_or:   alu_out = a | b;
      op_xor:  alu_out = a ^ b;
      op_sll:  alu_out = a << b[4:0];
      op_srl:  alu_out = a >> b[4:0];
      op_slt:  alu_out = {{(DATA_W - 1){1'b0}}, $signed(a) < $signed(b)};
      default: alu_out = '0;
    endcase
  end

  // free slot, or current result leaves this cycle
  assign can_accept = !full_q || result_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      full_q <= 1'b0;
    end else if (go) begin
      full_q <= 1'b1;
    end else if (result_ready) begin
      full_q <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (go) begin
      tag_q   <= issue.uop.dst_tag;
      value_q <= alu_out;
    end
  end

  assign res_valid = full_q;
  assign res       = '{valid: full_q, tag: tag_q, value: value_q};
  // consumed == broadcast
  assign cdb       = '{valid: full_q && result_ready, tag: tag_q, value: value_q};

  // selector must respect the lane's backpressure
  a_go_accept : assert property (
    @(posedge clk) disable iff (!rst_n)
    go |-> can_accept
  ) else $error("go while lane cannot accept");

  // a held result stays put until taken
  a_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    full_q && !result_ready |=> full_q && $stable(tag_q) && $stable(value_q)
  ) else $error("stalled result changed");

endmodule

// File: hdl/issue_select.sv
`timescale 1ns/1ps

module issue_select #(
  parameter int RS_DEPTH = 8
) (
  input  logic [RS_DEPTH-1:0]         ready_mask,
  input  logic                        can_accept_0,
  input  logic                        can_accept_1,
  output logic [$clog2(RS_DEPTH)-1:0] sel_idx_0,
  output logic [$clog2(RS_DEPTH)-1:0] sel_idx_1,
  output logic [RS_DEPTH-1:0]         issue_grant,
  output logic                        lane_go_0,
  output logic                        lane_go_1
);

  localparam int idx_w = $clog2(RS_DEPTH);

  logic             first_found;
  logic             second_found;
  logic [idx_w-1:0] first_idx;
  logic [idx_w-1:0] second_idx;

  // first and second set bits, lowest index first
  always_comb begin
    first_found  = 1'b0;
    second_found = 1'b0;
    first_idx    = '0;
    second_idx   = '0;
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (ready_mask[i]) begin
        if (!first_found) begin
          first_found = 1'b1;
          first_idx   = idx_w'(i);
        end else if (!second_found) begin
          second_found = 1'b1;
          second_idx   = idx_w'(i);
        end
      end
    end
  end

  assign sel_idx_0 = first_idx;
  assign lane_go_0 = can_accept_0 && first_found;

  // lane 1 moves up to the oldest pick when lane 0 is blocked
  assign sel_idx_1 = can_accept_0 ? second_idx : first_idx;
  assign lane_go_1 = can_accept_1 && (can_accept_0 ? second_found : first_found);

  always_comb begin
    issue_grant = '0;
    if (lane_go_0) issue_grant[sel_idx_0] = 1'b1;
    if (lane_go_1) issue_grant[sel_idx_1] = 1'b1;
  end

  always_comb begin
    a_distinct : assert final (!(lane_go_0 && lane_go_1 && sel_idx_0 == sel_idx_1))
      else $error("both lanes granted the same entry");
  end

endmodule

// File: hdl/ooo_issue_top.sv
`timescale 1ns/1ps

module ooo_issue_top import ooo_pkg::*; #(
  parameter int RS_DEPTH = 8,
  parameter int TAG_W    = 6,
  parameter int DATA_W   = 32
) (
  input  logic      clk,
  input  logic      rst_n,
  input  logic      disp_valid,
  input  dispatch_t disp,
  input  logic      result_ready,
  output logic      disp_ready,
  output logic      res_valid_0,
  output cdb_t      res_0,
  output logic      res_valid_1,
  output cdb_t      res_1
);

  localparam int idx_w = $clog2(RS_DEPTH);

  logic [RS_DEPTH-1:0] busy_vector;
  logic [RS_DEPTH-1:0] entry_wen;
  logic [RS_DEPTH-1:0] ready_mask;
  logic [RS_DEPTH-1:0] issue_grant;
  logic [idx_w-1:0]    sel_idx_0;
  logic [idx_w-1:0]    sel_idx_1;
  logic                lane_go_0;
  logic                lane_go_1;
  logic                can_accept_0;
  logic                can_accept_1;
  issue_t              issue_0;
  issue_t              issue_1;
  cdb_t                cdb [0:1];  // lane n from alu n

  rs_alloc #(
    .RS_DEPTH(RS_DEPTH)
  ) u_alloc (
    .clk        (clk),
    .rst_n      (rst_n),
    .disp_valid (disp_valid),
    .busy_vector(busy_vector),
    .disp_ready (disp_ready),
    .entry_wen  (entry_wen)
  );

  reservation_station #(
    .RS_DEPTH(RS_DEPTH),
    .TAG_W   (TAG_W),
    .DATA_W  (DATA_W)
  ) u_rs (
    .clk        (clk),
    .rst_n      (rst_n),
    .entry_wen  (entry_wen),
    .disp       (disp),
    .cdb        (cdb),
    .issue_grant(issue_grant),
    .sel_idx_0  (sel_idx_0),
    .sel_idx_1  (sel_idx_1),
    .busy_vector(busy_vector),
    .ready_mask (ready_mask),
    .issue_0    (issue_0),
    .issue_1    (issue_1)
  );

  issue_select #(
    .RS_DEPTH(RS_DEPTH)
  ) u_sel (
    .ready_mask  (ready_mask),
    .can_accept_0(can_accept_0),
    .can_accept_1(can_accept_1),
    .sel_idx_0   (sel_idx_0),
    .sel_idx_1   (sel_idx_1),
    .issue_grant (issue_grant),
    .lane_go_0   (lane_go_0),
    .lane_go_1   (lane_go_1)
  );

  alu_unit #(.TAG_W(TAG_W), .DATA_W(DATA_W)) alu0 (
    .clk(clk), .rst_n(rst_n), .go(lane_go_0), .issue(issue_0),
    .result_ready(result_ready), .can_accept(can_accept_0),
    .res_valid(res_valid_0), .res(res_0), .cdb(cdb[0])
  );

  alu_unit #(.TAG_W(TAG_W), .DATA_W(DATA_W)) alu1 (
    .clk(clk), .rst_n(rst_n), .go(lane_go_1), .issue(issue_1),
    .result_ready(result_ready), .can_accept(can_accept_1),
    .res_valid(res_valid_1), .res(res_1), .cdb(cdb[1])
  );

endmodule

// File: hdl/ooo_pkg.sv
package ooo_pkg;

  // struct widths; module DATA_W / TAG_W must equal these
  localparam int data_w_c = 32;
  localparam int tag_w_c  = 6;

  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_and = 3'd2,
    op_or  = 3'd3,
    op_xor = 3'd4,
    op_sll = 3'd5,  // shamt is src2[4:0]
    op_srl = 3'd6,
    op_slt = 3'd7   // signed, gives 1 or 0
  } alu_op_t;

  // executed part of a micro-op
  typedef struct packed {
    alu_op_t             op;
    logic [tag_w_c-1:0]  dst_tag;
  } uop_t;

  typedef struct packed {
    uop_t                uop;
    logic [data_w_c-1:0] v1;  // operand value
    logic [tag_w_c-1:0]  q1;  // awaited tag
    logic                r1;  // v1 already valid
    logic [data_w_c-1:0] v2;
    logic [tag_w_c-1:0]  q2;
    logic                r2;
  } dispatch_t;

  // one lane of the result bus
  typedef struct packed {
    logic                valid;
    logic [tag_w_c-1:0]  tag;
    logic [data_w_c-1:0] value;
  } cdb_t;

  typedef struct packed {
    uop_t                uop;
    logic [data_w_c-1:0] v1;
    logic [data_w_c-1:0] v2;
  } issue_t;

endpackage

// File: hdl/reservation_station.sv
`timescale 1ns/1ps

module reservation_station import ooo_pkg::*; #(
  parameter int RS_DEPTH = 8,
  parameter int TAG_W    = 6,
  parameter int DATA_W   = 32
) (
  input  logic                        clk,
  input  logic                        rst_n,
  input  logic [RS_DEPTH-1:0]         entry_wen,
  input  dispatch_t                   disp,
  input  cdb_t                        cdb [0:1],
  input  logic [RS_DEPTH-1:0]         issue_grant,
  input  logic [$clog2(RS_DEPTH)-1:0] sel_idx_0,
  input  logic [$clog2(RS_DEPTH)-1:0] sel_idx_1,
  output logic [RS_DEPTH-1:0]         busy_vector,
  output logic [RS_DEPTH-1:0]         ready_mask,
  output issue_t                      issue_0,
  output issue_t                      issue_1
);

  // struct fields are sized by the package constants
  if (TAG_W != tag_w_c || DATA_W != data_w_c) begin : g_width_check
    $error("TAG_W/DATA_W differ from ooo_pkg widths");
  end

  logic [RS_DEPTH-1:0] busy;

  uop_t              uop_arr [RS_DEPTH];
  logic [DATA_W-1:0] v1_arr  [RS_DEPTH];
  logic [TAG_W-1:0]  q1_arr  [RS_DEPTH];
  logic              r1_arr  [RS_DEPTH];
  logic [DATA_W-1:0] v2_arr  [RS_DEPTH];
  logic [TAG_W-1:0]  q2_arr  [RS_DEPTH];
  logic              r2_arr  [RS_DEPTH];

  // returns {ready, value} after looking at both bus lanes
  function automatic logic [DATA_W:0] snoop(input logic              r,
                                            input logic [DATA_W-1:0] v,
                                            input logic [TAG_W-1:0]  q);
    logic [DATA_W:0] rv;
    rv = {r, v};
    if (!r) begin
      for (int k = 0; k < 2; k++) begin
        if (cdb[k].valid && cdb[k].tag == q) begin
          rv = {1'b1, cdb[k].value};
        end
      end
    end
    return rv;
  endfunction

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= '0;
    end else begin
      for (int i = 0; i < RS_DEPTH; i++) begin
        if (issue_grant[i]) begin
          busy[i] <= 1'b0;  // grant wins over write
        end else if (entry_wen[i]) begin
          busy[i] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      if (entry_wen[i]) begin
        uop_arr[i]             <= disp.uop;
        q1_arr[i]              <= disp.q1;
        q2_arr[i]              <= disp.q2;
        // catch a result broadcast on the write edge
        {r1_arr[i], v1_arr[i]} <= snoop(disp.r1, disp.v1, disp.q1);
        {r2_arr[i], v2_arr[i]} <= snoop(disp.r2, disp.v2, disp.q2);
      end else if (busy[i]) begin
        {r1_arr[i], v1_arr[i]} <= snoop(r1_arr[i], v1_arr[i], q1_arr[i]);
        {r2_arr[i], v2_arr[i]} <= snoop(r2_arr[i], v2_arr[i], q2_arr[i]);
      end
    end
  end

  always_comb begin
    for (int i = 0; i < RS_DEPTH; i++) begin
      ready_mask[i] = busy[i] && r1_arr[i] && r2_arr[i];
    end
  end

  assign busy_vector = busy;

  // read channels, one per ALU lane
  assign issue_0 = '{uop: uop_arr[sel_idx_0], v1: v1_arr[sel_idx_0], v2: v2_arr[sel_idx_0]};
  assign issue_1 = '{uop: uop_arr[sel_idx_1], v1: v1_arr[sel_idx_1], v2: v2_arr[sel_idx_1]};

  // selector may only grant entries with both operands in
  a_grant_ready : assert property (
    @(posedge clk) disable iff (!rst_n)
    (issue_grant & ~ready_mask) == '0
  ) else $error("granted an entry that was not ready");

endmodule

// File: hdl/rs_alloc.sv
`timescale 1ns/1ps

module rs_alloc #(
  parameter int RS_DEPTH = 8
) (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                disp_valid,
  input  logic [RS_DEPTH-1:0] busy_vector,
  output logic                disp_ready,
  output logic [RS_DEPTH-1:0] entry_wen
);

  logic [RS_DEPTH-1:0] first_free;  // one-hot, lowest free slot
  logic                xfer;

  // priority encoder over ~busy, low index wins
  always_comb begin
    first_free = '0;
    for (int i = RS_DEPTH - 1; i >= 0; i--) begin
      if (!busy_vector[i]) begin
        first_free    = '0;
        first_free[i] = 1'b1;
      end
    end
  end

  assign disp_ready = ~&busy_vector;
  assign xfer       = disp_valid && disp_ready;
  assign entry_wen  = xfer ? first_free : '0;

  // write must land in a free slot, at most one per cycle
  a_wen_free : assert property (
    @(posedge clk) disable iff (!rst_n)
    $onehot0(entry_wen) && ((entry_wen & busy_vector) == '0)
  ) else $error("allocator wrote a busy entry or more than one entry");

  // dispatch must hold while stalled
  a_disp_hold : assert property (
    @(posedge clk) disable iff (!rst_n)
    disp_valid && !disp_ready |=> disp_valid
  ) else $error("dispatch valid dropped while stalled");

endmodule

// File: ooo_issue.f
+incdir+testbench
hdl/ooo_pkg.sv
hdl/rs_alloc.sv
hdl/reservation_station.sv
hdl/issue_select.sv
hdl/alu_unit.sv
hdl/ooo_issue_top.sv
testbench/tb_ooo_issue.sv

// File: testbench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// scoreboard, one slot per tag
logic [31:0] exp_val [64];
logic        pend    [64];  // dispatched, result not yet taken
logic        seen    [64];  // result already taken at a result port
int          outstanding = 0;
int          errors = 0;
int          checks = 0;
int          next_tag = 0;
int          recent [8];    // last dispatched tags
int          recent_cnt = 0;

logic [31:0] rng = 32'hde4701bc;
logic [31:0] stall_rng = 32'hde4701bc;

function automatic logic [31:0] xorshift(input logic [31:0] x);
  logic [31:0] y;
  y = x;
  y = y ^ (y << 13);
  y = y ^ (y >> 17);
  y = y ^ (y << 5);
  return y;
endfunction

function logic [31:0] rnd();
  rng = xorshift(rng);
  return rng;
endfunction

// expected result from the opcode definitions
function automatic logic [31:0] alu_ref(input alu_op_t op, input logic [31:0] a,
                                        input logic [31:0] b);
  logic [4:0] sh;
  sh = b[4:0];
  case (op)
    op_add: return a + b;
    op_sub: return a - b;
    op_and: return a & b;
    op_or:  return a | b;
    op_xor: return a ^ b;
    op_sll: return a << sh;
    op_srl: return a >> sh;
    default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
  endcase
endfunction

// round robin over tags, skips those still in flight
function int alloc_tag();
  int t;
  t = next_tag;
  while (pend[t]) t = (t + 1) % 64;
  next_tag = (t + 1) % 64;
  return t;
endfunction

function int pick_recent();
  int n;
  n = (recent_cnt < 8) ? recent_cnt : 8;
  return recent[rnd() % n];
endfunction

`endif

// File: testbench/tb_ooo_issue.sv
`timescale 1ns/1ps

module tb_ooo_issue import ooo_pkg::*;;
  logic      clk;
  logic      rst_n;
  logic      disp_valid;
  dispatch_t disp;
  logic      result_ready;
  logic      disp_ready;
  logic      res_valid_0;
  logic      res_valid_1;
  cdb_t      res_0;
  cdb_t      res_1;
  logic      stall_en = 0;
  logic      hold_low = 0;

  localparam int n_indep = 40;
  localparam int n_chain = 24;
  localparam int n_fwd   = 16;
  localparam int n_bp    = 11;
  localparam int n_mix   = 120;
  localparam int total_uops = n_indep + n_chain + n_fwd + n_bp + n_mix;

  `include "tb_model.svh"

  ooo_issue_top #(.RS_DEPTH(8), .TAG_W(6), .DATA_W(32)) dut0 (
    .clk(clk), .rst_n(rst_n), .disp_valid(disp_valid), .disp(disp),
    .result_ready(result_ready), .disp_ready(disp_ready),
    .res_valid_0(res_valid_0), .res_0(res_0), .res_valid_1(res_valid_1), .res_1(res_1)
  );

  initial begin
    clk = 0;
    forever #50 clk = ~clk;
  end

  // result_ready pattern, changed 5 ns after each edge
  initial begin
    result_ready = 1;
    forever begin
      @(posedge clk);
      #5;
      if (hold_low) begin
        result_ready = 0;
      end else if (stall_en) begin
        stall_rng = xorshift(stall_rng);
        result_ready = stall_rng[1:0] != 2'b00;
      end else begin
        result_ready = 1;
      end
    end
  end

  task automatic take_result(input cdb_t r);
    checks++;
    if (!pend[r.tag]) begin
      errors++;
      $display("result for tag %0d arrived with no micro-op waiting for it", r.tag);
    end else begin
      if (r.value !== exp_val[r.tag]) begin
        errors++;
        $display("Fail %0t: tag %0d value %h expected %h", $time, r.tag, r.value,
                 exp_val[r.tag]);
      end
      pend[r.tag] = 0;
      seen[r.tag] = 1;
      outstanding--;
    end
  endtask

  // sampled mid-cycle, taken at the next edge
  always @(negedge clk) begin
    if (rst_n && result_ready) begin
      if (res_valid_0) take_result(res_0);
      if (res_valid_1) take_result(res_1);
    end
  end

  // src < 0 gives a literal, otherwise the tag of an earlier micro-op
  task automatic make_src(input int src, output logic [31:0] v, output logic [5:0] q,
                          output logic r, output logic [31:0] val);
    v = rnd();
    q = '0;
    r = 1;
    if (src >= 0) begin
      val = exp_val[src];
      if (seen[src]) begin
        v = val;
      end else begin
        q = 6'(src);
        r = 0;
      end
    end else begin
      val = v;
    end
  endtask

  task automatic build_uop(input alu_op_t op, input int s1, input int s2);
    dispatch_t   d;
    int          t;
    logic [31:0] a;
    logic [31:0] b;
    if (s1 >= 0 || s2 >= 0) begin
      while (!disp_ready) begin  // room first, so a tag is never missed while stalled
        @(posedge clk);
        #5;
      end
    end
    t = alloc_tag();
    d = '0;
    d.uop.op = op;
    d.uop.dst_tag = 6'(t);
    make_src(s1, d.v1, d.q1, d.r1, a);
    make_src(s2, d.v2, d.q2, d.r2, b);
    exp_val[t] = alu_ref(op, a, b);
    pend[t] = 1;
    seen[t] = 0;
    outstanding++;
    recent[recent_cnt % 8] = t;
    recent_cnt++;
    disp = d;
    disp_valid = 1;
  endtask

  task automatic finish_handshake();
    do @(negedge clk); while (!disp_ready);
    @(posedge clk);
    #5;
    disp_valid = 0;
  endtask

  task automatic send_uop(input alu_op_t op, input int s1, input int s2);
    build_uop(op, s1, s2);
    finish_handshake();
  endtask

  // gives up after a bounded wait, leftovers stay pending
  task automatic drain();
    int w;
    w = 0;
    while (outstanding > 0 && w < 400) begin
      @(posedge clk);
      #5;
      w++;
    end
  endtask

  task automatic report(input string name, input int err_before);
    $display("test %s done, %0d errors", name, errors - err_before);
  endtask

  initial begin
    int e0;
    int p;
    int acc;
    disp_valid = 0;
    disp = '0;
    rst_n = 0;
    for (int i = 0; i < 64; i++) begin
      pend[i] = 0;
      seen[i] = 0;
      exp_val[i] = '0;
    end
    repeat (2) @(posedge clk);
    #5;
    rst_n = 1;
    if (!disp_ready || res_valid_0 || res_valid_1) begin
      errors++;
      $display("Fail %0t: outputs after reset not idle", $time);
    end

    e0 = errors;
    for (int i = 0; i < n_indep; i++) send_uop(alu_op_t'(i % 8), -1, -1);
    drain();
    report("independent_ops", e0);

    e0 = errors;
    for (int c = 0; c < n_chain / 6; c++) begin
      send_uop(alu_op_t'(rnd() % 8), -1, -1);
      for (int k = 1; k < 6; k++) begin
        p = recent[(recent_cnt - 1) % 8];
        send_uop(alu_op_t'(rnd() % 8), p, (k > 1) ? recent[(recent_cnt - 2) % 8] : -1);
      end
    end
    drain();
    report("dependency_chains", e0);

    e0 = errors;
    for (int i = 0; i < n_fwd / 2; i++) begin
      send_uop(op_add, -1, -1);
      p = recent[(recent_cnt - 1) % 8];
      for (int w = 0; w < 20; w++) begin  // wait until the producer holds its result
        if ((res_valid_0 && res_0.tag == p) || (res_valid_1 && res_1.tag == p)) break;
        @(posedge clk);
        #5;
      end
      if (i % 2 == 0) send_uop(alu_op_t'(rnd() % 8), p, -1);
      else send_uop(alu_op_t'(rnd() % 8), -1, p);
      drain();
    end
    report("same_edge_forwarding", e0);

    e0 = errors;
    hold_low = 1;
    repeat (2) begin
      @(posedge clk);
      #5;
    end
    acc = 0;
    for (int i = 0; i < n_bp - 1; i++) begin
      if (!disp_ready) begin
        errors++;
        $display("Fail %0t: disp_ready fell after %0d accepted", $time, acc);
        break;
      end
      send_uop(alu_op_t'(rnd() % 8), -1, -1);
      acc++;
    end
    build_uop(op_xor, -1, -1);
    repeat (3) begin
      @(negedge clk);
      if (disp_ready) begin
        errors++;
        $display("Fail %0t: disp_ready high with %0d accepted and no drain", $time, acc);
      end
    end
    hold_low = 0;
    finish_handshake();
    drain();
    report("back_pressure", e0);

    e0 = errors;
    stall_en = 1;
    for (int i = 0; i < n_mix; i++) begin
      send_uop(alu_op_t'(rnd() % 8), (rnd() % 4 == 0) ? -1 : pick_recent(),
               (rnd() % 2 == 0) ? -1 : pick_recent());
    end
    stall_en = 0;
    drain();
    for (int i = 0; i < 64; i++) begin
      if (pend[i]) begin
        errors++;
        $display("tag %0d never came back", i);
      end
    end
    report("random_mix", e0);

    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    #((total_uops * 40 + 200) * 100);
    $display("watchdog expired with %0d results still outstanding", outstanding);
    $display("TB FAILED");
    $finish;
  end

endmodule
